/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f sha_regs_top.f --top-module sha_regs_tb \
  --Mdir obj_dir -o sha_regs_sim

./obj_dir/sha_regs_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* sha_regs_top.f */
+incdir+src
src/sha_regs_pkg.sv
src/block_fifo_if.sv
src/sys_bus_slave.sv
src/block_assembler.sv
src/hash_capture.sv
src/sha_regs_top.sv
tb/sha_regs_properties.sv
tb/sha_regs_tb.sv

/* src/block_assembler.sv */
`timescale 1ns/10ps
`include "sha_regs_settings.svh"

module block_assembler
  import sha_regs_pkg::*;
(
  input  logic            clk_100mhz,
  input  logic            rstn_i,
  block_fifo_if.assembler fifo,
  output logic            blk_valid_o,
  output msg_block_t      blk_data_o,
  input  logic            blk_ready_i
);

  localparam int DEPTH  = `SHA_FIFO_BLOCKS * `SHA_WORDS_PER_BLOCK;
  localparam int PTR_W  = $clog2(DEPTH);
  localparam int BLK_W  = $clog2(`SHA_FIFO_BLOCKS);
  localparam int WIDX_W = $clog2(`SHA_WORDS_PER_BLOCK);
  localparam fifo_level_t LVL_FULL  = fifo_level_t'(DEPTH);
  localparam fifo_level_t LVL_BLOCK = fifo_level_t'(`SHA_WORDS_PER_BLOCK);

  fifo_word_t       mem [DEPTH];   // block storage
  bus_word_t        lo_half_q;     // even push waiting for its partner
  logic             half_q;        // next push is the high half
  logic [PTR_W-1:0] wr_ptr_q;
  logic [BLK_W-1:0] rd_blk_q;      // reads go a whole block at a time
  fifo_level_t      count_q;
  logic             word_wr;
  logic             blk_pop;

  assign word_wr = fifo.push_valid & half_q & ~fifo.full & ~fifo.flush;
  assign blk_pop = blk_valid_o & blk_ready_i;

  // -------------------
  // half-word pairing and pointers
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i || fifo.flush) begin
      half_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_blk_q <= '0;
      count_q  <= '0;
    end else begin
      if (fifo.push_valid) begin
        half_q <= ~half_q; // toggles even when the word is dropped
      end
      if (word_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (blk_pop) begin
        rd_blk_q <= rd_blk_q + 1'b1;
      end
      case ({word_wr, blk_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - LVL_BLOCK;
        2'b11:   count_q <= count_q - (LVL_BLOCK - 1'b1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (fifo.push_valid && !half_q) begin
      lo_half_q <= fifo.push_data;
    end
    if (word_wr) begin
      mem[wr_ptr_q] <= {fifo.push_data, lo_half_q}; // odd push on top
    end
  end

  // -------------------
  // block output, word 0 highest
  always_comb begin
    for (int p = 0; p < `SHA_WORDS_PER_BLOCK; p++) begin
      blk_data_o[`BLOCK_W-1-`FIFO_WORD_W*p -: `FIFO_WORD_W] = mem[{rd_blk_q, WIDX_W'(p)}];
    end
  end

  assign blk_valid_o = (count_q >= LVL_BLOCK) & ~fifo.flush; // nothing offered while disabled

  assign fifo.empty       = (count_q == '0);
  assign fifo.almost_full = (count_q >= LVL_FULL - 1'b1);
  assign fifo.full        = (count_q == LVL_FULL);

endmodule

/* src/block_fifo_if.sv */
`timescale 1ns/10ps

interface block_fifo_if
  import sha_regs_pkg::*;
();

  logic      push_valid;  // one-cycle pulse per bus push
  bus_word_t push_data;
  logic      flush;       // high while the engine is disabled

  // level flags back to the status register
  logic      empty;
  logic      almost_full;
  logic      full;

  modport slave (
    output push_valid, push_data, flush,
    input  empty, almost_full, full
  );

  modport assembler (
    input  push_valid, push_data, flush,
    output empty, almost_full, full
  );

endinterface

/* src/hash_capture.sv */
`timescale 1ns/10ps
`include "sha_regs_settings.svh"

module hash_capture
  import sha_regs_pkg::*;
(
  input  logic      clk_100mhz,
  input  logic      rstn_i,
  input  logic      enable_i,      // engine enable from the bus slave
  input  logic      hash_valid_i,
  input  hash_t     hash_i,
  input  hash_sel_t hash_rd_sel_i,
  output bus_word_t hash_rd_word_o
);

  logic  valid_d_q; // valid seen in the previous cycle
  hash_t hash_q;

  // -------------------
  // capture on rising valid only
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      valid_d_q <= 1'b0;
      hash_q    <= '0;
    end else if (!enable_i) begin
      valid_d_q <= 1'b0; // next valid after re-enable counts as new
    end else begin
      valid_d_q <= hash_valid_i;
      if (hash_valid_i && !valid_d_q) begin
        hash_q <= hash_i; // held valid does not reload
      end
    end
  end

  // word k is bits 32k and up
  assign hash_rd_word_o = hash_q[`BUS_DATA_W*hash_rd_sel_i +: `BUS_DATA_W];

endmodule

/* src/sha_regs_pkg.sv */
`include "sha_regs_settings.svh"

package sha_regs_pkg;

  // -------------------
  // bus side
  typedef logic [`BUS_ADDR_W-1:0]   bus_addr_t;   // low 20 address bits only
  typedef logic [`BUS_DATA_W-1:0]   bus_word_t;

  // -------------------
  // message path
  typedef logic [`FIFO_WORD_W-1:0]  fifo_word_t;  // {odd push, even push}
  typedef logic [`BLOCK_W-1:0]      msg_block_t;  // word 0 in the top 64 bits
  typedef logic [`FIFO_LEVEL_W-1:0] fifo_level_t; // occupancy in 64-bit words

  // -------------------
  // digest path
  typedef logic [`HASH_W-1:0]       hash_t;
  typedef logic [`HASH_SEL_W-1:0]   hash_sel_t;   // word k = bits 32k and up

endpackage

/* src/sha_regs_settings.svh */
`ifndef SHA_REGS_SETTINGS_SVH
`define SHA_REGS_SETTINGS_SVH

// -------------------
// widths
`define BUS_ADDR_W          20   // decoded part of the bus address
`define BUS_DATA_W          32
`define FIFO_WORD_W         64   // two pushes per fifo word
`define BLOCK_W             512
`define HASH_W              256
`define FIFO_LEVEL_W        6    // holds 0..32
`define HASH_SEL_W          3
`define SHA_HASH_WORDS      8
`define SHA_WORDS_PER_BLOCK 8    // 64-bit words in one message block
`define SHA_FIFO_BLOCKS     4    // 32 fifo words in total

// -------------------
// register map
`define ADDR_CTRL           20'h00000
`define ADDR_STATUS         20'h00004
`define ADDR_VERSION        20'h0000C
`define ADDR_SHA_CTRL       20'h00100
`define ADDR_SHA_STATUS     20'h00104
`define ADDR_SHA_PUSH       20'h0010C
`define ADDR_SHA_HASH0      20'h00110 // eight words up to 0x12C

`define BUILD_DATE          32'h24110501 // YYMMDDss

// -------------------
// bit positions
`define CTRL_ENABLE         0
`define SHA_CTRL_RESET      0
`define ST_ACTIVE           0
`define ST_SHA_EN           4
`define SST_READY           0
`define SST_HASH_VALID      1
`define SST_EMPTY           4
`define SST_ALMOST_FULL     5
`define SST_FULL            6
`define SHA_CTRL_KEEP_MASK  32'h0000_fff0 // low nibble is one-shot

`endif

/* src/sha_regs_top.sv */
`timescale 1ns/10ps

module sha_regs_top
  import sha_regs_pkg::*;
(
  input  logic       clk_100mhz,
  input  logic       rstn_i,
  // system bus
  input  bus_addr_t  sys_addr_i,
  input  bus_word_t  sys_wdata_i,
  input  logic       sys_wen_i,
  input  logic       sys_ren_i,
  output bus_word_t  sys_rdata_o,
  output logic       sys_ack_o,
  // external engine
  output logic       blk_valid_o,
  output msg_block_t blk_data_o,
  input  logic       blk_ready_i,
  input  logic       hash_valid_i,
  input  hash_t      hash_i
);

  logic      sha_en;        // engine enable, also gates hash capture
  hash_sel_t hash_rd_sel;
  bus_word_t hash_rd_word;

  block_fifo_if fifo_bus ();

  sys_bus_slave i_bus_slave (
    .clk_100mhz     (clk_100mhz),
    .rstn_i         (rstn_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .fifo           (fifo_bus.slave),
    .blk_ready_i    (blk_ready_i),
    .hash_valid_i   (hash_valid_i),
    .hash_rd_word_i (hash_rd_word),
    .hash_rd_sel_o  (hash_rd_sel),
    .sha_en_o       (sha_en)
  );

  block_assembler i_block_assembler (
    .clk_100mhz  (clk_100mhz),
    .rstn_i      (rstn_i),
    .fifo        (fifo_bus.assembler),
    .blk_valid_o (blk_valid_o),
    .blk_data_o  (blk_data_o),
    .blk_ready_i (blk_ready_i)
  );

  hash_capture i_hash_capture (
    .clk_100mhz     (clk_100mhz),
    .rstn_i         (rstn_i),
    .enable_i       (sha_en),
    .hash_valid_i   (hash_valid_i),
    .hash_i         (hash_i),
    .hash_rd_sel_i  (hash_rd_sel),
    .hash_rd_word_o (hash_rd_word)
  );

endmodule

/* src/sys_bus_slave.sv */
`timescale 1ns/10ps
`include "sha_regs_settings.svh"

module sys_bus_slave
  import sha_regs_pkg::*;
(
  input  logic        clk_100mhz,
  input  logic        rstn_i,
  input  bus_addr_t   sys_addr_i,
  input  bus_word_t   sys_wdata_i,
  input  logic        sys_wen_i,
  input  logic        sys_ren_i,
  output bus_word_t   sys_rdata_o,
  output logic        sys_ack_o,
  block_fifo_if.slave fifo,
  input  logic        blk_ready_i,     // engine can take a block
  input  logic        hash_valid_i,
  input  bus_word_t   hash_rd_word_i,
  output hash_sel_t   hash_rd_sel_o,
  output logic        sha_en_o
);

  bus_word_t ctrl_q;       // bit 0 activates the block
  bus_word_t sha_ctrl_q;
  bus_word_t push_data_q;
  logic      push_q;
  logic      sha_en;
  bus_word_t status;
  bus_word_t sha_status;
  bus_addr_t hash_off;
  logic      hash_hit;
  bus_word_t rd_mux;
  bus_word_t rdata_q;
  logic      ack_q;

  // -------------------
  // engine enable and status words
  assign sha_en = ctrl_q[`CTRL_ENABLE] & ~sha_ctrl_q[`SHA_CTRL_RESET];
  assign sha_en_o = sha_en;

  always_comb begin
    status = '0;
    status[`ST_ACTIVE] = ctrl_q[`CTRL_ENABLE];
    status[`ST_SHA_EN] = sha_en;
    sha_status = '0;
    sha_status[`SST_READY]       = blk_ready_i;
    sha_status[`SST_HASH_VALID]  = hash_valid_i;
    sha_status[`SST_EMPTY]       = fifo.empty;
    sha_status[`SST_ALMOST_FULL] = fifo.almost_full;
    sha_status[`SST_FULL]        = fifo.full;
  end

  // -------------------
  // register writes
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      push_q     <= 1'b0;
    end else begin
      sha_ctrl_q <= sha_ctrl_q & `SHA_CTRL_KEEP_MASK; // one-shot bits drop after a cycle
      push_q     <= 1'b0;
      if (sys_wen_i) begin
        case (sys_addr_i)
          `ADDR_CTRL:     ctrl_q     <= sys_wdata_i;
          `ADDR_SHA_CTRL: sha_ctrl_q <= sys_wdata_i;
          `ADDR_SHA_PUSH: push_q     <= 1'b1;      // data follows in push_data_q
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_wen_i) begin
      push_data_q <= sys_wdata_i; // only meaningful with push_q
    end
  end

  assign fifo.push_valid = push_q;
  assign fifo.push_data  = push_data_q;
  assign fifo.flush      = ~sha_en; // fifo and half word cleared while disabled

  // -------------------
  // read path
  assign hash_off      = sys_addr_i - `ADDR_SHA_HASH0;
  assign hash_hit      = (hash_off < bus_addr_t'(4 * `SHA_HASH_WORDS)) &&
                         (hash_off[1:0] == 2'b00);
  assign hash_rd_sel_o = hash_off[`HASH_SEL_W+1:2]; // word index from byte offset

  always_comb begin
    rd_mux = '0; // unmapped reads give zero
    case (sys_addr_i)
      `ADDR_CTRL:       rd_mux = ctrl_q;
      `ADDR_STATUS:     rd_mux = status;
      `ADDR_VERSION:    rd_mux = `BUILD_DATE;
      `ADDR_SHA_CTRL:   rd_mux = sha_ctrl_q;
      `ADDR_SHA_STATUS: rd_mux = sha_status;
      default: begin
        if (hash_hit) begin
          rd_mux = hash_rd_word_i;
        end
      end
    endcase
  end

  // ack and data one cycle after every access
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q   <= sys_wen_i | sys_ren_i;
      rdata_q <= sys_ren_i ? rd_mux : '0;
    end
  end

  assign sys_ack_o   = ack_q;
  assign sys_rdata_o = rdata_q;

endmodule

/* tb/sha_regs_properties.sv */
`timescale 1ns/10ps

module sha_regs_properties
  import sha_regs_pkg::*;
(
  input logic       clk_100mhz,
  input logic       rstn_i,
  input logic       wen_i,
  input logic       ren_i,
  input logic       ack_i,
  input logic       blk_valid_i,
  input logic       blk_ready_i,
  input msg_block_t blk_data_i,
  input logic       sha_en_i
);

  // --------------------
  // bus ack, exactly one cycle after each access
  ack_after_req: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    (wen_i || ren_i) |=> ack_i)
    else $error("bus ack missing one cycle after a request");

  ack_only_after_req: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    !(wen_i || ren_i) |=> !ack_i)
    else $error("bus ack without a request in the cycle before");

  // --------------------
  // engine port
  blk_held: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    (blk_valid_i && !blk_ready_i) |=> (!blk_valid_i || $stable(blk_data_i)))
    else $error("block data changed while waiting for ready");

  blk_off_when_disabled: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
    !sha_en_i |=> !blk_valid_i) // stored blocks gone once flushed
    else $error("block offered after the engine was disabled");

endmodule

bind sha_regs_top sha_regs_properties props_i (
  .clk_100mhz  (clk_100mhz),
  .rstn_i      (rstn_i),
  .wen_i       (sys_wen_i),
  .ren_i       (sys_ren_i),
  .ack_i       (sys_ack_o),
  .blk_valid_i (blk_valid_o),
  .blk_ready_i (blk_ready_i),
  .blk_data_i  (blk_data_o),
  .sha_en_i    (sha_en)
);

/* tb/sha_regs_tb.sv */
`timescale 1ns/10ps
`include "sha_regs_settings.svh"

module sha_regs_tb
  import sha_regs_pkg::*;
();

  localparam int N_TESTS     = 6;
  localparam int MODEL_DEPTH = `SHA_FIFO_BLOCKS * `SHA_WORDS_PER_BLOCK; // 64-bit words
  localparam logic [31:0] SEED = 32'h3afc0447;
  localparam int READY_LOW  = 0;
  localparam int READY_HIGH = 1;
  localparam int READY_RAND = 2;

  logic       clk_100mhz;
  logic       rstn;
  bus_addr_t  sys_addr;
  bus_word_t  sys_wdata;
  logic       sys_wen;
  logic       sys_ren;
  bus_word_t  sys_rdata;
  logic       sys_ack;
  logic       blk_valid;
  msg_block_t blk_data;
  logic       blk_ready;
  logic       hash_valid;
  hash_t      hash;

  logic [31:0] lfsr_q;        // stimulus data
  logic [31:0] ready_lfsr;    // ready pattern, own state
  int          ready_mode;
  fifo_word_t  model_words[$]; // reference fifo contents
  bus_word_t   lo_half;
  logic        half_odd;
  hash_t       model_hash;
  int errors, err_mark, test_no, tests_bad, blocks_seen, blk_mark;

  sha_regs_top sha_regs_top_i (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn),
    .sys_addr_i   (sys_addr),
    .sys_wdata_i  (sys_wdata),
    .sys_wen_i    (sys_wen),
    .sys_ren_i    (sys_ren),
    .sys_rdata_o  (sys_rdata),
    .sys_ack_o    (sys_ack),
    .blk_valid_o  (blk_valid),
    .blk_data_o   (blk_data),
    .blk_ready_i  (blk_ready),
    .hash_valid_i (hash_valid),
    .hash_i       (hash)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  // --------------------
  // random numbers
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois, taps 32 22 2 1
  endfunction

  function automatic bus_word_t take_bits(input int n);
    bus_word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]}; // one step per bit
    end
    return r;
  endfunction

  function automatic hash_t take_hash();
    hash_t h;
    for (int k = 0; k < `SHA_HASH_WORDS; k++) begin
      h[32*k +: 32] = take_bits(32);
    end
    return h;
  endfunction

  // --------------------
  // reference model
  task automatic model_push(input bus_word_t d);
    if (!half_odd) begin
      lo_half  = d; // even push, low half
      half_odd = 1'b1;
    end else begin
      half_odd = 1'b0;
      if (model_words.size() < MODEL_DEPTH) begin
        model_words.push_back({d, lo_half});
      end // else dropped, fifo full
    end
  endtask

  task automatic model_flush();
    model_words.delete();
    half_odd = 1'b0;
  endtask

  function automatic bus_word_t expect_sha_status(input logic rdy, input logic hv);
    bus_word_t s;
    s = '0;
    s[`SST_READY]       = rdy;
    s[`SST_HASH_VALID]  = hv;
    s[`SST_EMPTY]       = (model_words.size() == 0);
    s[`SST_ALMOST_FULL] = (model_words.size() >= MODEL_DEPTH - 1);
    s[`SST_FULL]        = (model_words.size() == MODEL_DEPTH);
    return s;
  endfunction

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // --------------------
  // bus access
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_100mhz);
      #1;
    end
  endtask

  task automatic wait_ack(input bus_addr_t a);
    int n;
    n = 0;
    while (!sys_ack && n < 4) begin
      @(posedge clk_100mhz);
      #1;
      n++;
    end
    if (!sys_ack) begin
      $display("no ack for the access to address %0h at %0t", a, $time);
      errors++;
    end
  endtask

  task automatic write_reg(input bus_addr_t a, input bus_word_t d);
    sys_addr  = a;
    sys_wdata = d;
    sys_wen   = 1'b1;
    @(posedge clk_100mhz);
    #1;
    sys_wen = 1'b0;
    wait_ack(a);
    if (a == `ADDR_SHA_PUSH) begin
      model_push(d);
    end else if ((a == `ADDR_SHA_CTRL && d[`SHA_CTRL_RESET]) ||
                 (a == `ADDR_CTRL && !d[`CTRL_ENABLE])) begin
      model_flush(); // engine disabled, fifo cleared
    end
  endtask

  task automatic read_check(input bus_addr_t a, input bus_word_t exp, input string name);
    sys_addr = a;
    sys_ren  = 1'b1;
    @(posedge clk_100mhz);
    #1;
    sys_ren = 1'b0;
    wait_ack(a);
    check_value(name, sys_rdata, exp);
  endtask

  task automatic push_words(input int n);
    repeat (n) write_reg(`ADDR_SHA_PUSH, take_bits(32));
  endtask

  task automatic wait_drain(input int max_cycles);
    int n;
    n = 0;
    while (model_words.size() != 0 && n < max_cycles) begin
      @(posedge clk_100mhz);
      #1;
      n++;
    end
    if (model_words.size() != 0) begin
      $display("blocks not drained after %0d cycles, %0d words left", n, model_words.size());
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d mismatches", test_no, name, errors - err_mark);
    if (errors != err_mark) tests_bad++;
    test_no++;
    err_mark = errors;
  endtask

  // --------------------
  // engine model, ready pattern and block capture
  initial begin
    blk_ready  = 1'b0;
    ready_lfsr = SEED;
    forever begin
      @(posedge clk_100mhz);
      #1;
      ready_lfsr = lfsr_step(ready_lfsr);
      case (ready_mode)
        READY_LOW:  blk_ready = 1'b0;
        READY_HIGH: blk_ready = 1'b1;
        default:    blk_ready = ready_lfsr[0];
      endcase
    end
  end

  task automatic take_block(input msg_block_t got);
    msg_block_t exp;
    blocks_seen++;
    if (model_words.size() < `SHA_WORDS_PER_BLOCK) begin
      $display("block transferred at %0t while the model holds no full block", $time);
      errors++;
    end else begin
      for (int p = 0; p < `SHA_WORDS_PER_BLOCK; p++) begin
        exp[(7-p)*64 +: 64] = model_words.pop_front(); // word 0 on top
      end
      check_value("blk_data_o", got, exp);
    end
  endtask

  always @(negedge clk_100mhz) begin
    if (rstn && blk_valid && blk_ready) begin
      take_block(blk_data); // transfer at the next rising edge
    end
  end

  initial begin
    repeat (N_TESTS * 2000) @(posedge clk_100mhz);
    $display("watchdog expired after %0d cycles, tests did not finish", N_TESTS * 2000);
    $display("Something failed");
    $finish;
  end

  // --------------------
  // test sequence
  initial begin
    bus_word_t r;
    rstn = 1'b0;
    sys_addr = '0;
    sys_wdata = '0;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    hash_valid = 1'b0;
    hash = '0;
    ready_mode = READY_LOW;
    lfsr_q = SEED;
    half_odd = 1'b0;
    lo_half = '0;
    model_hash = '0;
    errors = 0;
    err_mark = 0;
    test_no = 1;
    tests_bad = 0;
    blocks_seen = 0;
    repeat (16) @(posedge clk_100mhz);
    #1;
    rstn = 1'b1;
    wait_cycles(2);

    // registers, status and decode
    read_check(`ADDR_SHA_STATUS, expect_sha_status(1'b0, 1'b0), "sha status after reset");
    read_check(`ADDR_VERSION, `BUILD_DATE, "version");
    r = take_bits(32);
    write_reg(`ADDR_CTRL, r);
    read_check(`ADDR_CTRL, r, "ctrl readback");
    write_reg(`ADDR_CTRL, 32'h1);
    read_check(`ADDR_STATUS, (32'h1 << `ST_ACTIVE) | (32'h1 << `ST_SHA_EN), "status");
    read_check(20'h00200, 32'h0, "unmapped read");
    end_test("registers");

    // sha control one-shot bits
    r = take_bits(32);
    write_reg(`ADDR_SHA_CTRL, r);
    wait_cycles(1);
    read_check(`ADDR_SHA_CTRL, r & `SHA_CTRL_KEEP_MASK, "sha ctrl readback");
    write_reg(`ADDR_SHA_CTRL, 32'h1);
    read_check(`ADDR_STATUS, 32'h1 << `ST_ACTIVE, "status during engine reset");
    read_check(`ADDR_STATUS, (32'h1 << `ST_ACTIVE) | (32'h1 << `ST_SHA_EN), "status after");
    end_test("sha control");

    // random blocks with random ready
    blk_mark = blocks_seen;
    ready_mode = READY_RAND;
    push_words(6 * 16);
    wait_drain(400);
    wait_cycles(2);
    check_value("blocks transferred", 512'(blocks_seen - blk_mark), 512'(6));
    ready_mode = READY_LOW;
    wait_cycles(2);
    end_test("random blocks");

    // back-pressure up to full
    blk_mark = blocks_seen;
    push_words(62);
    wait_cycles(2);
    read_check(`ADDR_SHA_STATUS, expect_sha_status(1'b0, 1'b0), "sha status at 31 words");
    push_words(18); // nine more words, eight of them dropped
    wait_cycles(2);
    read_check(`ADDR_SHA_STATUS, expect_sha_status(1'b0, 1'b0), "sha status when full");
    ready_mode = READY_HIGH;
    wait_drain(200);
    wait_cycles(2);
    read_check(`ADDR_SHA_STATUS, expect_sha_status(1'b1, 1'b0), "sha status drained");
    check_value("blocks transferred", 512'(blocks_seen - blk_mark), 512'(4));
    end_test("back-pressure");

    // hash capture on rising valid
    hash = take_hash();
    hash_valid = 1'b1;
    model_hash = hash;
    wait_cycles(2);
    for (int k = 0; k < `SHA_HASH_WORDS; k++) begin
      read_check(`ADDR_SHA_HASH0 + bus_addr_t'(4 * k), model_hash[32*k +: 32], "hash word");
    end
    read_check(`ADDR_SHA_STATUS, expect_sha_status(1'b1, 1'b1), "sha status hash valid");
    hash = take_hash(); // valid still high, must not reload
    wait_cycles(2);
    for (int k = 0; k < `SHA_HASH_WORDS; k++) begin
      read_check(`ADDR_SHA_HASH0 + bus_addr_t'(4 * k), model_hash[32*k +: 32], "held hash");
    end
    hash_valid = 1'b0;
    end_test("hash capture");

    // engine reset in the middle of a block
    ready_mode = READY_LOW;
    wait_cycles(2);
    blk_mark = blocks_seen;
    push_words(37); // two blocks, two words and a half word
    write_reg(`ADDR_SHA_CTRL, 32'h1);
    wait_cycles(2);
    read_check(`ADDR_SHA_STATUS, expect_sha_status(1'b0, 1'b0), "sha status after flush");
    ready_mode = READY_RAND;
    push_words(16);
    wait_drain(200);
    wait_cycles(2);
    check_value("blocks transferred", 512'(blocks_seen - blk_mark), 512'(1));
    end_test("engine reset");

    $display("tests run %0d, tests with mismatches %0d, mismatches %0d",
             test_no - 1, tests_bad, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
